/* hw/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Geometry of the four-way data cache
`define CACHE_WAYS 4
`define CACHE_SETS 8
`define CACHE_INDEX_BITS 3
`define CACHE_TAG_BITS 8

// 15-bit physical address, tag | index | byte offset
`define CACHE_ADDR_BITS 15

// One line is 16 bytes
`define CACHE_LINE_BITS 128

`endif

/* hw/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_fill  = 2'd2
    } cache_op_e;

    typedef enum logic [2:0] {
        st_hit      = 3'd0,
        st_miss     = 3'd1,
        st_stall    = 3'd2,
        st_uncached = 3'd3,
        st_filled   = 3'd4
    } cache_status_e;

    // Mask bit set means the data bit is written
    typedef struct packed {
        cache_op_e                    op;
        logic [`CACHE_ADDR_BITS-1:0]  addr;
        logic [`CACHE_LINE_BITS-1:0]  data;
        logic [`CACHE_LINE_BITS-1:0]  mask;
        logic                         uncached;
    } cache_req_t;

    typedef struct packed {
        cache_status_e                status;
        logic [1:0]                   way;
        logic [`CACHE_LINE_BITS-1:0]  line;
        logic                         evict;
        logic [`CACHE_ADDR_BITS-1:0]  evict_addr;
        logic [`CACHE_LINE_BITS-1:0]  evict_line;
    } cache_resp_t;

    // Decode to execute bundle, all from pre-edge state
    typedef struct packed {
        cache_req_t                                 req;
        logic [`CACHE_INDEX_BITS-1:0]               index;
        logic [`CACHE_TAG_BITS-1:0]                 tag;
        logic                                       hit;
        logic [1:0]                                 hit_way;
        logic [`CACHE_WAYS-1:0]                     valid_set;
        logic [`CACHE_WAYS*`CACHE_TAG_BITS-1:0]     tags_set;
    } cache_lookup_t;

endpackage

`default_nettype wire

/* hw/cache_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  cache_pkg::cache_req_t    req,
    input  logic                     tag_we,
    input  logic [1:0]               tag_way,
    output cache_pkg::cache_lookup_t lookup
);

    logic [`CACHE_TAG_BITS-1:0] tag_mem [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]     valid_mem [`CACHE_SETS];

    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [`CACHE_TAG_BITS-1:0]   tag;
    logic [`CACHE_WAYS-1:0]       match;

    // Byte offset sits below the index and is not used here
    assign tag   = req.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign index = req.addr[`CACHE_ADDR_BITS-`CACHE_TAG_BITS-1 -: `CACHE_INDEX_BITS];

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = valid_mem[index][w] && (tag_mem[index][w] == tag);
        end
    end

    always_comb begin
        lookup.req       = req;
        lookup.index     = index;
        lookup.tag       = tag;
        lookup.hit       = |match;
        lookup.hit_way   = 2'd0;
        lookup.valid_set = valid_mem[index];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            lookup.tags_set[w*`CACHE_TAG_BITS +: `CACHE_TAG_BITS] = tag_mem[index][w];
            if (match[w]) begin
                lookup.hit_way = 2'(w);
            end
        end
    end

    // Valid flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (req_valid && tag_we) begin
            valid_mem[index][tag_way] <= 1'b1;
        end
    end

    // Tag store
    always_ff @(posedge clk) begin
        if (req_valid && tag_we) begin
            tag_mem[index][tag_way] <= tag;
        end
    end

    // Fills refresh a present tag, so a second copy never appears
    a_single_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid |-> $onehot0(match)
    );

endmodule

`default_nettype wire

/* hw/cache_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  cache_pkg::cache_lookup_t  lookup,
    input  logic                      queue_full,
    output logic                      stall,
    output logic                      tag_we,
    output logic [1:0]                tag_way,
    output logic                      line_we,
    output logic [1:0]                line_way,
    output logic                      line_fill,
    output logic                      victim_dirty,
    output cache_pkg::cache_status_e  status
);

    logic [1:0]             age_mem [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] dirty_mem [`CACHE_SETS];

    logic       cached;
    logic       is_fill;
    logic       is_write;
    logic       touch;
    logic [1:0] lru_way;
    logic [1:0] free_way;
    logic [1:0] victim;
    logic [1:0] access_way;
    logic [1:0] access_age;
    logic [`CACHE_WAYS-1:0] age_seen;
    logic       ages_ok;

    assign cached   = !lookup.req.uncached;
    assign is_fill  = lookup.req.op == cache_pkg::op_fill;
    assign is_write = lookup.req.op == cache_pkg::op_write;

    // Refresh a present line before taking the lowest invalid or oldest way
    always_comb begin
        lru_way = 2'd0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (age_mem[lookup.index][w] == 2'(`CACHE_WAYS - 1)) begin
                lru_way = 2'(w);
            end
        end
        free_way = lru_way;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!lookup.valid_set[w]) begin
                free_way = 2'(w);
            end
        end
        victim = lookup.hit ? lookup.hit_way : free_way;
    end

    assign access_way = is_fill ? victim : lookup.hit_way;
    assign access_age = age_mem[lookup.index][access_way];

    // Only cached hits and fills touch state
    assign touch = req_valid && cached && (is_fill || lookup.hit);

    assign stall = req_valid && cached && !is_fill && !lookup.hit && queue_full;

    assign tag_we    = touch && is_fill;
    assign tag_way   = access_way;
    assign line_we   = touch && (is_fill || is_write);
    assign line_way  = access_way;
    assign line_fill = is_fill;

    // A refresh replaces nothing
    assign victim_dirty = touch && is_fill && !lookup.hit &&
                          lookup.valid_set[victim] && dirty_mem[lookup.index][victim];

    always_comb begin
        if (!cached) begin
            status = cache_pkg::st_uncached;
        end else if (is_fill) begin
            status = cache_pkg::st_filled;
        end else if (lookup.hit) begin
            status = cache_pkg::st_hit;
        end else if (queue_full) begin
            status = cache_pkg::st_stall;
        end else begin
            status = cache_pkg::st_miss;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                dirty_mem[s] <= '0;
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    age_mem[s][w] <= 2'(w);
                end
            end
        end else if (touch) begin
            // Accessed way becomes youngest and younger ones shift up
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (2'(w) == access_way) begin
                    age_mem[lookup.index][w] <= 2'd0;
                end else if (age_mem[lookup.index][w] < access_age) begin
                    age_mem[lookup.index][w] <= age_mem[lookup.index][w] + 2'd1;
                end
            end
            if (is_fill) begin
                dirty_mem[lookup.index][access_way] <= 1'b0;
            end else if (is_write) begin
                dirty_mem[lookup.index][access_way] <= 1'b1;
            end
        end
    end

    always_comb begin
        ages_ok  = 1'b1;
        age_seen = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            age_seen = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                age_seen[age_mem[s][w]] = 1'b1;
            end
            if (age_seen != '1) begin
                ages_ok = 1'b0;
            end
        end
    end

    a_age_perm: assert property (@(posedge clk) disable iff (!rst_n) ages_ok);

endmodule

`default_nettype wire

/* hw/cache_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  cache_pkg::cache_lookup_t  lookup,
    input  logic                      line_we,
    input  logic [1:0]                line_way,
    input  logic                      line_fill,
    input  logic                      victim_dirty,
    input  cache_pkg::cache_status_e  status,
    output logic                      resp_valid,
    output cache_pkg::cache_resp_t    resp
);

    localparam int OFFSET_BITS = `CACHE_ADDR_BITS - `CACHE_TAG_BITS - `CACHE_INDEX_BITS;

    logic [`CACHE_LINE_BITS-1:0] line_mem [`CACHE_SETS][`CACHE_WAYS];

    logic [`CACHE_LINE_BITS-1:0] stored_line;
    logic [`CACHE_LINE_BITS-1:0] new_line;
    logic [`CACHE_LINE_BITS-1:0] resp_line;
    logic [`CACHE_TAG_BITS-1:0]  old_tag;
    logic [`CACHE_ADDR_BITS-1:0] evict_addr;

    assign stored_line = line_mem[lookup.index][line_way];

    // Fill replaces the line while a write merges under the mask
    assign new_line = line_fill ? lookup.req.data :
                      (stored_line & ~lookup.req.mask) | (lookup.req.data & lookup.req.mask);

    assign old_tag    = lookup.tags_set[line_way*`CACHE_TAG_BITS +: `CACHE_TAG_BITS];
    assign evict_addr = {old_tag, lookup.index, {OFFSET_BITS{1'b0}}};

    // Hits return the pre-edge line
    always_comb begin
        case (status)
            cache_pkg::st_hit:    resp_line = stored_line;
            cache_pkg::st_filled: resp_line = lookup.req.data;
            default:              resp_line = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            line_mem[lookup.index][line_way] <= new_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp.status     <= status;
            resp.way        <= line_way;
            resp.line       <= resp_line;
            resp.evict      <= victim_dirty;
            resp.evict_addr <= evict_addr;
            resp.evict_line <= stored_line;
        end
    end

endmodule

`default_nettype wire

/* hw/cache_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  cache_pkg::cache_req_t   req,
    input  logic                    queue_full,
    output logic                    stall,
    output logic                    resp_valid,
    output cache_pkg::cache_resp_t  resp
);

    cache_pkg::cache_lookup_t lookup;
    cache_pkg::cache_status_e status;

    logic       tag_we;
    logic [1:0] tag_way;
    logic       line_we;
    logic [1:0] line_way;
    logic       line_fill;
    logic       victim_dirty;

    // Tag lookup
    cache_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .tag_we    (tag_we),
        .tag_way   (tag_way),
        .lookup    (lookup)
    );

    // Replacement, dirty and LRU state
    cache_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .lookup       (lookup),
        .queue_full   (queue_full),
        .stall        (stall),
        .tag_we       (tag_we),
        .tag_way      (tag_way),
        .line_we      (line_we),
        .line_way     (line_way),
        .line_fill    (line_fill),
        .victim_dirty (victim_dirty),
        .status       (status)
    );

    // Line data and response register
    cache_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .lookup       (lookup),
        .line_we      (line_we),
        .line_way     (line_way),
        .line_fill    (line_fill),
        .victim_dirty (victim_dirty),
        .status       (status),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

endmodule

`default_nettype wire

/* bench/cache_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_stage_tb;

    localparam int TIMEOUT_CYCLES = 10;

    logic clk;
    logic rst_n;
    logic req_valid;
    logic queue_full;
    logic stall;
    logic resp_valid;
    cache_pkg::cache_req_t  req;
    cache_pkg::cache_resp_t resp;

    // Reference model with one entry per set and way
    logic [`CACHE_TAG_BITS-1:0]  tag_m   [`CACHE_SETS][`CACHE_WAYS];
    logic                        valid_m [`CACHE_SETS][`CACHE_WAYS];
    logic                        dirty_m [`CACHE_SETS][`CACHE_WAYS];
    logic [1:0]                  age_m   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_LINE_BITS-1:0] line_m  [`CACHE_SETS][`CACHE_WAYS];

    cache_pkg::cache_resp_t exp_resp;
    logic                   exp_stall;
    logic                   way_known;

    cache_stage UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .queue_full (queue_full),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_status(input cache_pkg::cache_status_e exp, act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error at %0t: resp.status expected %0d got %0d",
                                    $time, exp, act));
        end
    endtask

    task automatic check_way(input logic [1:0] exp, act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error at %0t: resp.way expected %0d got %0d",
                                    $time, exp, act));
        end
    endtask

    task automatic check_line(input string name, input logic [`CACHE_LINE_BITS-1:0] exp, act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error at %0t: %s expected %h got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic check_evict(input cache_pkg::cache_resp_t exp, act);
        if (act.evict !== exp.evict) begin
            stop_on_error($sformatf("Error at %0t: resp.evict expected %b got %b",
                                    $time, exp.evict, act.evict));
        end
        if (exp.evict && act.evict_addr !== exp.evict_addr) begin
            stop_on_error($sformatf("Error at %0t: resp.evict_addr expected %h got %h",
                                    $time, exp.evict_addr, act.evict_addr));
        end
        if (exp.evict) begin
            check_line("resp.evict_line", exp.evict_line, act.evict_line);
        end
    endtask

    task automatic check_stall(input logic exp, act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error at %0t: stall expected %b got %b", $time, exp, act));
        end
    endtask

    // Accessed way becomes age 0 and younger ways grow older by one
    task automatic touch_ages(input logic [2:0] idx, input logic [1:0] way);
        logic [1:0] old_age;
        old_age = age_m[idx][way];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (w == way) begin
                age_m[idx][w] = 2'd0;
            end else if (age_m[idx][w] < old_age) begin
                age_m[idx][w] = age_m[idx][w] + 2'd1;
            end
        end
    endtask

    task automatic predict(input cache_pkg::cache_req_t r, input logic qf);
        logic [2:0] idx;
        logic [7:0] tag;
        logic       hit;
        logic       found;
        logic [1:0] hw;
        logic [1:0] v;
        idx = r.addr[6:4];
        tag = r.addr[14:7];
        hit = 1'b0;
        hw = 2'd0;
        v = 2'd0;
        found = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (valid_m[idx][w] && tag_m[idx][w] == tag) begin
                hit = 1'b1;
                hw = 2'(w);
            end
        end
        exp_resp = '0;
        exp_stall = 1'b0;
        way_known = 1'b0;
        if (r.uncached) begin
            exp_resp.status = cache_pkg::st_uncached;
        end else if (r.op == cache_pkg::op_fill) begin
            if (hit) begin
                v = hw;
            end else begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    if (!found && !valid_m[idx][w]) begin
                        v = 2'(w);
                        found = 1'b1;
                    end
                end
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    if (!found && age_m[idx][w] == 2'd3) begin
                        v = 2'(w);
                    end
                end
                exp_resp.evict = valid_m[idx][v] && dirty_m[idx][v];
                exp_resp.evict_addr = {tag_m[idx][v], idx, 4'b0000};
                exp_resp.evict_line = line_m[idx][v];
            end
            exp_resp.status = cache_pkg::st_filled;
            exp_resp.way = v;
            exp_resp.line = r.data;
            way_known = 1'b1;
            tag_m[idx][v] = tag;
            valid_m[idx][v] = 1'b1;
            dirty_m[idx][v] = 1'b0;
            line_m[idx][v] = r.data;
            touch_ages(idx, v);
        end else if (hit) begin
            exp_resp.status = cache_pkg::st_hit;
            exp_resp.way = hw;
            exp_resp.line = line_m[idx][hw];
            way_known = 1'b1;
            if (r.op == cache_pkg::op_write) begin
                line_m[idx][hw] = (line_m[idx][hw] & ~r.mask) | (r.data & r.mask);
                dirty_m[idx][hw] = 1'b1;
            end
            touch_ages(idx, hw);
        end else if (qf) begin
            exp_resp.status = cache_pkg::st_stall;
            exp_stall = 1'b1;
        end else begin
            exp_resp.status = cache_pkg::st_miss;
        end
    endtask

    // Hex digits or the word rand
    function automatic logic [`CACHE_LINE_BITS-1:0] token_value(input logic [8*40-1:0] tok);
        logic [`CACHE_LINE_BITS-1:0] val;
        logic [7:0] c;
        val = '0;
        if (tok == "rand") begin
            val = {$urandom, $urandom, $urandom, $urandom};
        end else begin
            for (int i = 39; i >= 0; i--) begin
                c = tok[i*8 +: 8];
                if (c >= "0" && c <= "9") begin
                    val = {val[`CACHE_LINE_BITS-5:0], 4'(c - "0")};
                end else if (c >= "a" && c <= "f") begin
                    val = {val[`CACHE_LINE_BITS-5:0], 4'(c - "a" + 8'd10)};
                end
            end
        end
        return val;
    endfunction

    task automatic run_vector(input cache_pkg::cache_req_t r, input logic qf,
                              input logic [8*40-1:0] tok_exp, input int vec_no);
        int waited;
        predict(r, qf);
        if (tok_exp != "-" && ((tok_exp == "hit") != (exp_resp.status == cache_pkg::st_hit) ||
            (tok_exp == "miss") != (exp_resp.status == cache_pkg::st_miss) ||
            (tok_exp == "stall") != (exp_resp.status == cache_pkg::st_stall) ||
            (tok_exp == "unc") != (exp_resp.status == cache_pkg::st_uncached) ||
            (tok_exp == "fill") != (exp_resp.status == cache_pkg::st_filled))) begin
            stop_on_error($sformatf("Vector %0d: data file status disagrees with the model",
                                    vec_no));
        end
        @(negedge clk);
        if (resp_valid !== 1'b0) begin
            stop_on_error("resp_valid stayed high for more than one cycle");
        end
        req = r;
        queue_full = qf;
        req_valid = 1'b1;
        #1;
        check_stall(exp_stall, stall);
        @(negedge clk);
        req_valid = 1'b0;
        queue_full = 1'b0;
        #1;
        check_stall(1'b0, stall);
        waited = 0;
        while (resp_valid !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (resp_valid !== 1'b1) begin
            stop_on_error($sformatf("Vector %0d: no response arrived within %0d cycles",
                                    vec_no, TIMEOUT_CYCLES));
        end
        if (waited != 0) begin
            stop_on_error($sformatf("Vector %0d: response came %0d cycles late", vec_no, waited));
        end
        check_status(exp_resp.status, resp.status);
        if (way_known) begin
            check_way(exp_resp.way, resp.way);
        end
        check_line("resp.line", exp_resp.line, resp.line);
        check_evict(exp_resp, resp);
    endtask

    initial begin
        int fd;
        int code;
        int vec_no;
        int addr_val;
        int unc_val;
        int qf_val;
        logic [8*40-1:0]  tok_op;
        logic [8*40-1:0]  tok_data;
        logic [8*40-1:0]  tok_mask;
        logic [8*40-1:0]  tok_exp;
        logic [8*200-1:0] skip_line;
        cache_pkg::cache_req_t r;
        void'($urandom(32'h1e12));
        vec_no = 0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        queue_full = 1'b0;
        req = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                tag_m[s][w] = '0;
                valid_m[s][w] = 1'b0;
                dirty_m[s][w] = 1'b0;
                age_m[s][w] = 2'(w);
                line_m[s][w] = '0;
            end
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("bench/cache_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open bench/cache_testdata.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok_op);
            if (code == 1 && tok_op == "#") begin
                code = $fgets(skip_line, fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%h %s %s %d %d %s", addr_val, tok_data, tok_mask,
                               unc_val, qf_val, tok_exp);
                if (code != 6) begin
                    stop_on_error($sformatf("Malformed data line after vector %0d", vec_no));
                end
                r = '0;
                if (tok_op == "rd") begin
                    r.op = cache_pkg::op_read;
                end else if (tok_op == "wr") begin
                    r.op = cache_pkg::op_write;
                end else if (tok_op == "fl") begin
                    r.op = cache_pkg::op_fill;
                end else begin
                    stop_on_error($sformatf("Unknown operation after vector %0d", vec_no));
                end
                r.addr = addr_val[`CACHE_ADDR_BITS-1:0];
                r.data = token_value(tok_data);
                r.mask = token_value(tok_mask);
                r.uncached = unc_val[0];
                vec_no++;
                run_vector(r, qf_val[0], tok_exp, vec_no);
            end
        end
        $fclose(fd);
        @(negedge clk);
        if (resp_valid !== 1'b0) begin
            stop_on_error("resp_valid stayed high for more than one cycle");
        end
        if (vec_no == 0) begin
            stop_on_error("No test vectors found in the data file");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/cache_testdata.txt */
# op addr data mask uncached queue_full expect
# data and mask are hex or rand, expect is hit miss stall unc fill or -
rd 0090 0 0 0 1 stall
rd 0090 0 0 0 0 miss
fl 0090 rand 0 0 0 fill
rd 0090 0 0 0 0 hit
rd 009c 0 0 0 1 hit
wr 0090 rand rand 0 0 hit
rd 0090 0 0 0 0 hit
wr 0094 0123456789abcdef0123456789abcdef ffffffff00000000ffffffff00000000 0 0 hit
rd 0090 0 0 0 0 hit
fl 0110 rand 0 0 0 fill
fl 0190 rand 0 0 0 fill
fl 0210 rand 0 0 0 fill
fl 0290 rand 0 0 0 fill
rd 0090 0 0 0 1 stall
rd 0090 0 0 0 0 miss
rd 0290 0 0 0 0 hit
rd 0190 0 0 0 0 hit
rd 0110 0 0 1 0 unc
wr 0190 rand rand 1 1 unc
rd 0190 0 0 0 0 hit
fl 0110 rand 0 1 0 unc
fl 0310 rand 0 0 0 fill
rd 0110 0 0 0 0 miss
rd 0310 0 0 0 0 hit
fl 0820 rand 0 0 0 fill
wr 0820 rand rand 0 0 hit
fl 0820 rand 0 0 0 fill
rd 0820 0 0 0 0 hit
fl 08a0 rand 0 0 0 fill
wr 08a0 rand rand 0 0 -
fl 0920 rand 0 0 0 fill
fl 09a0 rand 0 0 0 fill
fl 0a20 rand 0 0 0 fill
fl 0aa0 rand 0 0 0 fill
rd 08a0 0 0 0 0 miss
wr 5550 rand rand 0 1 stall
wr 5550 rand rand 0 0 miss
fl 5550 rand 0 0 0 fill
wr 555c rand rand 0 0 -
rd 5550 0 0 0 0 -
rd 0920 0 0 0 0 -
rd 7ff0 0 0 1 1 unc

/* src.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_decode.sv
hw/cache_execute.sv
hw/cache_result.sv
hw/cache_stage.sv
bench/cache_stage_tb.sv
